// File: Bender.yml
package:
  name: wb_commit

sources:
  - arch_pkg.sv
  - commit_pkg.sv
  - seq_arb.sv
  - rob.sv
  - writeback_commit_unit.sv
  - arch_regfile.sv
  - wb_commit_top.sv
  - target: test
    files:
      - tb_wb_commit.sv

// File: all.f
arch_pkg.sv
commit_pkg.sv
seq_arb.sv
rob.sv
writeback_commit_unit.sv
arch_regfile.sv
wb_commit_top.sv
tb_wb_commit.sv

// File: arch_pkg.sv
/*
  ISA-level widths for the writeback and commit datapath.
  RV32-style machine with 32 architectural integer registers.
  Register 0 is hard-wired to zero by the register file.
*/

package arch_pkg;

  // ------------------------------------------------
  // Datapath widths
  // ------------------------------------------------

  // Data word and program counter
  parameter int XLEN = 32;

  // ------------------------------------------------
  // Architectural register space
  // ------------------------------------------------

  // Index width of an architectural register
  parameter int AREG_BITS = 5;

  // Registers addressable by AREG_BITS
  parameter int NUM_AREGS = 1 << AREG_BITS;

endpackage

// File: arch_regfile.sv
/*
  Architectural register file written only at commit.
  Register 0 reads zero whatever is written to it, the read port is combinational.
*/
`timescale 1ns/1ps

module arch_regfile (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           wen,
  input  logic [arch_pkg::AREG_BITS-1:0] waddr,
  input  logic [arch_pkg::XLEN-1:0]      wdata,
  input  logic [arch_pkg::AREG_BITS-1:0] raddr,
  output logic [arch_pkg::XLEN-1:0]      rdata
);

  logic [arch_pkg::XLEN-1:0] regs [arch_pkg::NUM_AREGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < arch_pkg::NUM_AREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen) begin
      regs[waddr] <= wdata;
    end
  end

  // Debug read, new data visible the cycle after the commit
  assign rdata = (raddr == '0) ? '0 : regs[raddr];

endmodule

// File: commit_pkg.sv
/*
  Encodings used inside the writeback and commit stage.
  Slot state belongs to the reorder buffer, grant result to the arbiter.
*/

package commit_pkg;

  // ------------------------------------------------
  // Reorder buffer slot state
  // ------------------------------------------------

  // A slot is done once its result has been written
  typedef enum logic {
    SLOT_EMPTY = 1'b0,
    SLOT_DONE  = 1'b1
  } slot_state_e;

  // ------------------------------------------------
  // Arbiter outcome
  // ------------------------------------------------

  // GRANT_ONE qualifies the selected pipe index
  typedef enum logic {
    GRANT_NONE = 1'b0,
    GRANT_ONE  = 1'b1
  } grant_e;

endpackage

// File: rob.sv
/*
  Reorder buffer indexed by sequence number, depth 2**SEQ_BITS.
  Inserts land anywhere, entries leave only from the head in order.
  A slot must not be reinserted before it has been dequeued.
*/
`timescale 1ns/1ps

module rob #(
  parameter int SEQ_BITS  = 3,
  parameter int PREG_BITS = 6
) (
  input  logic                           clk,
  input  logic                           rst,

  input  logic                           ins_en,
  input  logic [SEQ_BITS-1:0]            ins_idx,
  input  logic [arch_pkg::XLEN-1:0]      ins_pc,
  input  logic [arch_pkg::AREG_BITS-1:0] ins_waddr,
  input  logic [arch_pkg::XLEN-1:0]      ins_wdata,
  input  logic                           ins_wen,
  input  logic [PREG_BITS-1:0]           ins_ppreg,

  output logic [SEQ_BITS-1:0]            head,
  output logic                           deq_val,
  output logic [arch_pkg::XLEN-1:0]      deq_pc,
  output logic [arch_pkg::AREG_BITS-1:0] deq_waddr,
  output logic [arch_pkg::XLEN-1:0]      deq_wdata,
  output logic                           deq_wen,
  output logic [PREG_BITS-1:0]           deq_ppreg
);

  localparam int DEPTH = 1 << SEQ_BITS;

  commit_pkg::slot_state_e        state     [DEPTH];
  logic [arch_pkg::XLEN-1:0]      pc_mem    [DEPTH];
  logic [arch_pkg::AREG_BITS-1:0] waddr_mem [DEPTH];
  logic [arch_pkg::XLEN-1:0]      wdata_mem [DEPTH];
  logic                           wen_mem   [DEPTH];
  logic [PREG_BITS-1:0]           ppreg_mem [DEPTH];

  // ------------------------------------------------
  // Head of the buffer
  // ------------------------------------------------

  assign deq_val   = (state[head] == commit_pkg::SLOT_DONE);
  assign deq_pc    = pc_mem[head];
  assign deq_waddr = waddr_mem[head];
  assign deq_wdata = wdata_mem[head];
  assign deq_ppreg = ppreg_mem[head];

  // Stale slot contents must never write the register file
  assign deq_wen   = deq_val & wen_mem[head];

  // ------------------------------------------------
  // Slot state and head pointer
  // ------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      head <= '0;
      for (int i = 0; i < DEPTH; i++) begin
        state[i] <= commit_pkg::SLOT_EMPTY;
      end
    end else begin
      // Depth is a power of two, so the head wraps by overflow
      if (deq_val) begin
        state[head] <= commit_pkg::SLOT_EMPTY;
        head        <= head + 1'b1;
      end
      if (ins_en) begin
        state[ins_idx] <= commit_pkg::SLOT_DONE;
      end
    end
  end

  // Slot payload
  always_ff @(posedge clk) begin
    if (ins_en) begin
      pc_mem[ins_idx]    <= ins_pc;
      waddr_mem[ins_idx] <= ins_waddr;
      wdata_mem[ins_idx] <= ins_wdata;
      wen_mem[ins_idx]   <= ins_wen;
      ppreg_mem[ins_idx] <= ins_ppreg;
    end
  end

endmodule

// File: seq_arb.sv
/*
  Oldest-first arbiter over the execute pipes, purely combinational.
  Age is seq_num minus head modulo 2**SEQ_BITS, so no more than
  2**SEQ_BITS instructions may be in flight. Equal age goes to the lower index.
*/
`timescale 1ns/1ps

module seq_arb #(
  parameter int NUM_PIPES = 2,
  parameter int SEQ_BITS  = 3,
  parameter int IDX_BITS  = (NUM_PIPES > 1) ? $clog2(NUM_PIPES) : 1
) (
  input  logic [NUM_PIPES-1:0]               val,
  input  logic [NUM_PIPES-1:0][SEQ_BITS-1:0] seq_num,
  input  logic [SEQ_BITS-1:0]                head,
  output logic [NUM_PIPES-1:0]               gnt,
  output logic [IDX_BITS-1:0]                gnt_idx,
  output commit_pkg::grant_e                 result
);

  // Tree padded to a power of two, heap layout with root at node 0
  localparam int LEAVES = 1 << IDX_BITS;
  localparam int NODES  = 2 * LEAVES - 1;

  logic                node_val [NODES];
  logic [SEQ_BITS-1:0] node_age [NODES];
  logic [IDX_BITS-1:0] node_idx [NODES];

  always_comb begin
    // Pad leaves never win
    for (int i = 0; i < LEAVES; i++) begin
      node_val[LEAVES-1+i] = 1'b0;
      node_age[LEAVES-1+i] = '0;
      node_idx[LEAVES-1+i] = IDX_BITS'(i);
    end
    for (int i = 0; i < NUM_PIPES; i++) begin
      node_val[LEAVES-1+i] = val[i];
      node_age[LEAVES-1+i] = seq_num[i] - head;
    end

    // Reduce towards the root, left child holds the lower indices
    for (int n = LEAVES - 2; n >= 0; n--) begin
      if (node_val[2*n+1] &&
          (!node_val[2*n+2] || node_age[2*n+1] <= node_age[2*n+2])) begin
        node_val[n] = 1'b1;
        node_age[n] = node_age[2*n+1];
        node_idx[n] = node_idx[2*n+1];
      end else begin
        node_val[n] = node_val[2*n+2];
        node_age[n] = node_age[2*n+2];
        node_idx[n] = node_idx[2*n+2];
      end
    end
  end

  assign gnt_idx = node_idx[0];
  assign result  = node_val[0] ? commit_pkg::GRANT_ONE : commit_pkg::GRANT_NONE;

  // One-hot form of the winner
  always_comb begin
    for (int i = 0; i < NUM_PIPES; i++) begin
      gnt[i] = node_val[0] && (node_idx[0] == IDX_BITS'(i));
    end
  end

endmodule

// File: tb_wb_commit.sv
/*
  Testbench for the writeback and commit stage, two pipes, 8-entry ROB.
  A window of issued instructions drains completely before the next one starts.
  Inputs are driven 0.5 ns after the rising edge and outputs are sampled at the falling edge.
*/
`timescale 1ns/1ps

module tb_wb_commit;

  localparam int NP = 2;
  localparam int SB = 3;
  localparam int PB = 6;
  localparam int NUM_WIN = 6;

  logic clk = 1'b0;
  logic rst;
  logic [NP-1:0]                          ex_val;
  logic [NP-1:0]                          ex_rdy;
  logic [NP-1:0][SB-1:0]                  ex_seq_num;
  logic [NP-1:0][arch_pkg::XLEN-1:0]      ex_pc;
  logic [NP-1:0][arch_pkg::AREG_BITS-1:0] ex_waddr;
  logic [NP-1:0][arch_pkg::XLEN-1:0]      ex_wdata;
  logic [NP-1:0]                          ex_wen;
  logic [NP-1:0][PB-1:0]                  ex_preg;
  logic [NP-1:0][PB-1:0]                  ex_ppreg;
  logic                                   cpl_val;
  logic [SB-1:0]                          cpl_seq_num;
  logic [arch_pkg::AREG_BITS-1:0]         cpl_waddr;
  logic [arch_pkg::XLEN-1:0]              cpl_wdata;
  logic                                   cpl_wen;
  logic [PB-1:0]                          cpl_preg;
  logic                                   cmt_val;
  logic [SB-1:0]                          cmt_seq_num;
  logic [arch_pkg::XLEN-1:0]              cmt_pc;
  logic [arch_pkg::AREG_BITS-1:0]         cmt_waddr;
  logic [arch_pkg::XLEN-1:0]              cmt_wdata;
  logic                                   cmt_wen;
  logic [PB-1:0]                          cmt_ppreg;
  logic [arch_pkg::AREG_BITS-1:0]         dbg_raddr;
  logic [arch_pkg::XLEN-1:0]              dbg_rdata;

  wb_commit_top #(.NUM_PIPES(NP), .SEQ_BITS(SB), .PREG_BITS(PB)) UUT (.*);

  // Issued table, indexed by sequence number
  logic [arch_pkg::XLEN-1:0]      iss_pc    [8];
  logic [arch_pkg::AREG_BITS-1:0] iss_waddr [8];
  logic [arch_pkg::XLEN-1:0]      iss_wdata [8];
  logic                           iss_wen   [8];
  logic [PB-1:0]                  iss_preg  [8];
  logic [PB-1:0]                  iss_ppreg [8];
  logic                           pending   [8];
  logic                           inorder   [8];
  int                             xfer_cycle [8];
  logic [arch_pkg::XLEN-1:0]      model_regs [arch_pkg::NUM_AREGS];

  // Current window: issue slot k carries sequence perm[k]
  int perm [8];
  int pipe_of [8];
  int delay_of [8];
  int win_len [NUM_WIN];

  integer seed = 32'h42ef_b907;
  int cycle_cnt = 0;
  int cycle_limit = 1000;
  int issued_total = 0;
  int cmt_count = 0;
  int model_head = 0;
  int next_seq = 0;

  initial begin
    forever #2 clk = ~clk;
  end

  function automatic int rand_range(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  // ------------------------------------------------
  // Reference model
  // ------------------------------------------------

  // Expected commit record {pc, waddr, wdata, wen, ppreg}
  function automatic logic [79:0] expected_commit(input int s);
    return {iss_pc[s], iss_waddr[s], iss_wdata[s],
            iss_wen[s] && (iss_waddr[s] != 0), iss_ppreg[s]};
  endfunction

  function automatic logic [arch_pkg::XLEN-1:0] expected_reg(input int a);
    return (a == 0) ? '0 : model_regs[a];
  endfunction

  // Oldest relative to head wins, lower pipe on a tie
  function automatic logic [1:0] expected_rdy(input logic [1:0] v, input logic [SB-1:0] s0,
                                              input logic [SB-1:0] s1, input int hd);
    logic [SB-1:0] a0;
    logic [SB-1:0] a1;
    a0 = s0 - SB'(hd);
    a1 = s1 - SB'(hd);
    if (v[0] && (!v[1] || a0 <= a1))
      return 2'b01;
    else if (v[1])
      return 2'b10;
    return 2'b00;
  endfunction

  task automatic check(input string name, input logic [79:0] exp, input logic [79:0] act);
    if (exp !== act) begin
      $display("error %s: expected %h actual %h", name, exp, act);
      $display("Test FAILED");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  // ------------------------------------------------
  // Compare process
  // ------------------------------------------------

  always @(negedge clk) begin : compare
    logic [1:0] exp_rdy;
    int p;
    int s;
    if (!rst) begin
      exp_rdy = expected_rdy(ex_val, ex_seq_num[0], ex_seq_num[1], model_head);
      check("arbitration", exp_rdy, ex_rdy);
      check("completion valid", exp_rdy != 0, cpl_val);
      if (exp_rdy != 0) begin
        p = exp_rdy[1] ? 1 : 0;
        s = ex_seq_num[p];
        check("completion seq", s, cpl_seq_num);
        check("completion waddr", iss_waddr[s], cpl_waddr);
        check("completion wdata", iss_wdata[s], cpl_wdata);
        check("completion wen", iss_wen[s] && (iss_waddr[s] != 0), cpl_wen);
        check("completion preg", iss_preg[s], cpl_preg);
        xfer_cycle[s] = cycle_cnt;
      end
      if (cmt_val) begin
        s = cmt_seq_num;
        check("commit order", model_head, s);
        check("commit pending", 1'b1, pending[s]);
        check("commit record", expected_commit(s),
              {cmt_pc, cmt_waddr, cmt_wdata, cmt_wen, cmt_ppreg});
        if (inorder[s])
          check("commit latency", xfer_cycle[s] + 2, cycle_cnt);
        if (iss_wen[s])
          model_regs[iss_waddr[s]] = iss_wdata[s];
        pending[s] = 1'b0;
        model_head = (model_head + 1) % 8;
        cmt_count++;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout after %0d cycles, only %0d of %0d instructions committed",
               cycle_cnt, cmt_count, issued_total);
      $display("Test FAILED");
      $fatal(1, "timeout");
    end
  end

  // ------------------------------------------------
  // Stimulus
  // ------------------------------------------------

  // Window 0 is issued in order on pipe 0, later windows are shuffled over both pipes
  task automatic build_window(input int w);
    int n;
    int j;
    int t;
    n = win_len[w];
    for (int k = 0; k < n; k++) begin
      perm[k] = (next_seq + k) % 8;
      t = perm[k];
      iss_pc[t] = $random(seed);
      iss_waddr[t] = (rand_range(5) == 0) ? '0 : arch_pkg::AREG_BITS'(rand_range(32));
      iss_wdata[t] = $random(seed);
      iss_wen[t] = rand_range(4) != 0;
      iss_preg[t] = PB'(rand_range(64));
      iss_ppreg[t] = PB'(rand_range(64));
      pending[t] = 1'b1;
      inorder[t] = (w == 0);
      pipe_of[k] = (w == 0) ? 0 : rand_range(2);
      delay_of[k] = rand_range(3);
    end
    for (int k = n - 1; k > 0 && w != 0; k--) begin
      j = rand_range(k + 1);
      t = perm[k];
      perm[k] = perm[j];
      perm[j] = t;
    end
    next_seq = (next_seq + n) % 8;
    issued_total += n;
  endtask

  // Entered and left 0.5 ns after a rising edge
  task automatic run_pipe(input int p, input int n);
    int s;
    logic done;
    for (int k = 0; k < n; k++) begin
      if (pipe_of[k] == p) begin
        ex_val[p] = 1'b0;
        repeat (delay_of[k]) begin
          @(posedge clk);
          #0.5;
        end
        s = perm[k];
        ex_seq_num[p] = SB'(s);
        ex_pc[p] = iss_pc[s];
        ex_waddr[p] = iss_waddr[s];
        ex_wdata[p] = iss_wdata[s];
        ex_wen[p] = iss_wen[s];
        ex_preg[p] = iss_preg[s];
        ex_ppreg[p] = iss_ppreg[s];
        ex_val[p] = 1'b1;
        done = 1'b0;
        while (!done) begin
          @(negedge clk);
          done = ex_rdy[p];
          @(posedge clk);
          #0.5;
        end
      end
    end
    ex_val[p] = 1'b0;
  endtask

  initial begin
    rst = 1'b1;
    ex_val = '0;
    ex_seq_num = '0;
    ex_pc = '0;
    ex_waddr = '0;
    ex_wdata = '0;
    ex_wen = '0;
    ex_preg = '0;
    ex_ppreg = '0;
    dbg_raddr = '0;
    for (int i = 0; i < 8; i++) begin
      pending[i] = 1'b0;
      inorder[i] = 1'b0;
      xfer_cycle[i] = 0;
    end
    for (int i = 0; i < arch_pkg::NUM_AREGS; i++)
      model_regs[i] = '0;

    // Window 0 fills the ROB, total exceeds 8 so the sequence wraps
    win_len[0] = 8;
    for (int w = 1; w < NUM_WIN; w++)
      win_len[w] = 1 + rand_range(8);
    cycle_limit = 100;
    for (int w = 0; w < NUM_WIN; w++)
      cycle_limit += 40 * win_len[w];

    repeat (3) @(posedge clk);
    #0.5;
    rst = 1'b0;

    for (int w = 0; w < NUM_WIN; w++) begin
      build_window(w);
      fork
        run_pipe(0, win_len[w]);
        run_pipe(1, win_len[w]);
      join
      while (cmt_count != issued_total) begin
        @(posedge clk);
        #0.5;
      end
    end

    // Architectural state after the last commit
    @(posedge clk);
    #0.5;
    for (int a = 0; a < arch_pkg::NUM_AREGS; a++) begin
      dbg_raddr = arch_pkg::AREG_BITS'(a);
      @(negedge clk);
      check("regfile", expected_reg(a), dbg_rdata);
      @(posedge clk);
      #0.5;
    end

    $display("Test OK");
    $finish;
  end

endmodule

// File: wb_commit_top.sv
/*
  Top of the writeback and commit stage with its architectural register file.
  The front end keeps at most 2**SEQ_BITS instructions in flight.
*/
`timescale 1ns/1ps

module wb_commit_top #(
  parameter int NUM_PIPES = 2,
  parameter int SEQ_BITS  = 3,
  parameter int PREG_BITS = 6
) (
  input  logic                                          clk,
  input  logic                                          rst,

  input  logic [NUM_PIPES-1:0]                          ex_val,
  output logic [NUM_PIPES-1:0]                          ex_rdy,
  input  logic [NUM_PIPES-1:0][SEQ_BITS-1:0]            ex_seq_num,
  input  logic [NUM_PIPES-1:0][arch_pkg::XLEN-1:0]      ex_pc,
  input  logic [NUM_PIPES-1:0][arch_pkg::AREG_BITS-1:0] ex_waddr,
  input  logic [NUM_PIPES-1:0][arch_pkg::XLEN-1:0]      ex_wdata,
  input  logic [NUM_PIPES-1:0]                          ex_wen,
  input  logic [NUM_PIPES-1:0][PREG_BITS-1:0]           ex_preg,
  input  logic [NUM_PIPES-1:0][PREG_BITS-1:0]           ex_ppreg,

  output logic                                          cpl_val,
  output logic [SEQ_BITS-1:0]                           cpl_seq_num,
  output logic [arch_pkg::AREG_BITS-1:0]                cpl_waddr,
  output logic [arch_pkg::XLEN-1:0]                     cpl_wdata,
  output logic                                          cpl_wen,
  output logic [PREG_BITS-1:0]                          cpl_preg,

  output logic                                          cmt_val,
  output logic [SEQ_BITS-1:0]                           cmt_seq_num,
  output logic [arch_pkg::XLEN-1:0]                     cmt_pc,
  output logic [arch_pkg::AREG_BITS-1:0]                cmt_waddr,
  output logic [arch_pkg::XLEN-1:0]                     cmt_wdata,
  output logic                                          cmt_wen,
  output logic [PREG_BITS-1:0]                          cmt_ppreg,

  input  logic [arch_pkg::AREG_BITS-1:0]                dbg_raddr,
  output logic [arch_pkg::XLEN-1:0]                     dbg_rdata
);

  writeback_commit_unit #(
    .NUM_PIPES (NUM_PIPES),
    .SEQ_BITS  (SEQ_BITS),
    .PREG_BITS (PREG_BITS)
  ) wcu (
    .clk         (clk),
    .rst         (rst),
    .ex_val      (ex_val),
    .ex_rdy      (ex_rdy),
    .ex_seq_num  (ex_seq_num),
    .ex_pc       (ex_pc),
    .ex_waddr    (ex_waddr),
    .ex_wdata    (ex_wdata),
    .ex_wen      (ex_wen),
    .ex_preg     (ex_preg),
    .ex_ppreg    (ex_ppreg),
    .cpl_val     (cpl_val),
    .cpl_seq_num (cpl_seq_num),
    .cpl_waddr   (cpl_waddr),
    .cpl_wdata   (cpl_wdata),
    .cpl_wen     (cpl_wen),
    .cpl_preg    (cpl_preg),
    .cmt_val     (cmt_val),
    .cmt_seq_num (cmt_seq_num),
    .cmt_pc      (cmt_pc),
    .cmt_waddr   (cmt_waddr),
    .cmt_wdata   (cmt_wdata),
    .cmt_wen     (cmt_wen),
    .cmt_ppreg   (cmt_ppreg)
  );

  // Commit wen is already qualified by cmt_val
  arch_regfile arf (
    .clk   (clk),
    .rst   (rst),
    .wen   (cmt_wen),
    .waddr (cmt_waddr),
    .wdata (cmt_wdata),
    .raddr (dbg_raddr),
    .rdata (dbg_rdata)
  );

endmodule

// File: writeback_commit_unit.sv
/*
  Writeback and commit stage with one result accepted per cycle.
  Completion is broadcast in the transfer cycle, the ROB is written a cycle later.
  Commits are never back-pressured and writes to register 0 are dropped.
*/
`timescale 1ns/1ps

module writeback_commit_unit #(
  parameter int NUM_PIPES = 2,
  parameter int SEQ_BITS  = 3,
  parameter int PREG_BITS = 6
) (
  input  logic                                          clk,
  input  logic                                          rst,

  // Execute pipes
  input  logic [NUM_PIPES-1:0]                          ex_val,
  output logic [NUM_PIPES-1:0]                          ex_rdy,
  input  logic [NUM_PIPES-1:0][SEQ_BITS-1:0]            ex_seq_num,
  input  logic [NUM_PIPES-1:0][arch_pkg::XLEN-1:0]      ex_pc,
  input  logic [NUM_PIPES-1:0][arch_pkg::AREG_BITS-1:0] ex_waddr,
  input  logic [NUM_PIPES-1:0][arch_pkg::XLEN-1:0]      ex_wdata,
  input  logic [NUM_PIPES-1:0]                          ex_wen,
  input  logic [NUM_PIPES-1:0][PREG_BITS-1:0]           ex_preg,
  input  logic [NUM_PIPES-1:0][PREG_BITS-1:0]           ex_ppreg,

  // Completion notification
  output logic                                          cpl_val,
  output logic [SEQ_BITS-1:0]                           cpl_seq_num,
  output logic [arch_pkg::AREG_BITS-1:0]                cpl_waddr,
  output logic [arch_pkg::XLEN-1:0]                     cpl_wdata,
  output logic                                          cpl_wen,
  output logic [PREG_BITS-1:0]                          cpl_preg,

  // Commit notification
  output logic                                          cmt_val,
  output logic [SEQ_BITS-1:0]                           cmt_seq_num,
  output logic [arch_pkg::XLEN-1:0]                     cmt_pc,
  output logic [arch_pkg::AREG_BITS-1:0]                cmt_waddr,
  output logic [arch_pkg::XLEN-1:0]                     cmt_wdata,
  output logic                                          cmt_wen,
  output logic [PREG_BITS-1:0]                          cmt_ppreg
);

  localparam int IDX_BITS = (NUM_PIPES > 1) ? $clog2(NUM_PIPES) : 1;

  logic [NUM_PIPES-1:0]           gnt;
  logic [IDX_BITS-1:0]            gnt_idx;
  commit_pkg::grant_e             result;
  logic                           granted;
  logic [SEQ_BITS-1:0]            rob_head;

  logic [SEQ_BITS-1:0]            sel_seq_num;
  logic [arch_pkg::XLEN-1:0]      sel_pc;
  logic [arch_pkg::AREG_BITS-1:0] sel_waddr;
  logic [arch_pkg::XLEN-1:0]      sel_wdata;
  logic                           sel_wen;
  logic [PREG_BITS-1:0]           sel_preg;
  logic [PREG_BITS-1:0]           sel_ppreg;

  logic                           x_val;
  logic [SEQ_BITS-1:0]            x_seq_num;
  logic [arch_pkg::XLEN-1:0]      x_pc;
  logic [arch_pkg::AREG_BITS-1:0] x_waddr;
  logic [arch_pkg::XLEN-1:0]      x_wdata;
  logic                           x_wen;
  logic [PREG_BITS-1:0]           x_ppreg;

  // ------------------------------------------------
  // Pipe selection
  // ------------------------------------------------

  seq_arb #(
    .NUM_PIPES (NUM_PIPES),
    .SEQ_BITS  (SEQ_BITS),
    .IDX_BITS  (IDX_BITS)
  ) arb (
    .val     (ex_val),
    .seq_num (ex_seq_num),
    .head    (rob_head),
    .gnt     (gnt),
    .gnt_idx (gnt_idx),
    .result  (result)
  );

  assign granted = (result == commit_pkg::GRANT_ONE);

  always_comb begin
    for (int i = 0; i < NUM_PIPES; i++) begin
      ex_rdy[i] = granted && (gnt_idx == IDX_BITS'(i));
    end
  end

  // Masked OR over the one-hot grant
  always_comb begin
    sel_seq_num = '0;
    sel_pc      = '0;
    sel_waddr   = '0;
    sel_wdata   = '0;
    sel_wen     = 1'b0;
    sel_preg    = '0;
    sel_ppreg   = '0;
    for (int i = 0; i < NUM_PIPES; i++) begin
      sel_seq_num |= ex_seq_num[i] & {SEQ_BITS{gnt[i]}};
      sel_pc      |= ex_pc[i] & {arch_pkg::XLEN{gnt[i]}};
      sel_waddr   |= ex_waddr[i] & {arch_pkg::AREG_BITS{gnt[i]}};
      sel_wdata   |= ex_wdata[i] & {arch_pkg::XLEN{gnt[i]}};
      sel_wen     |= ex_wen[i] & gnt[i];
      sel_preg    |= ex_preg[i] & {PREG_BITS{gnt[i]}};
      sel_ppreg   |= ex_ppreg[i] & {PREG_BITS{gnt[i]}};
    end
  end

  // Completion goes out in the transfer cycle
  assign cpl_val     = granted;
  assign cpl_seq_num = sel_seq_num;
  assign cpl_waddr   = sel_waddr;
  assign cpl_wdata   = sel_wdata;
  assign cpl_wen     = sel_wen && (sel_waddr != '0);
  assign cpl_preg    = sel_preg;

  // ------------------------------------------------
  // X pipeline register
  // ------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      x_val <= 1'b0;
    end else begin
      x_val <= granted;
    end
  end

  always_ff @(posedge clk) begin
    if (granted) begin
      x_seq_num <= sel_seq_num;
      x_pc      <= sel_pc;
      x_waddr   <= sel_waddr;
      x_wdata   <= sel_wdata;
      x_wen     <= sel_wen;
      x_ppreg   <= sel_ppreg;
    end
  end

  // ------------------------------------------------
  // Reorder buffer
  // ------------------------------------------------

  rob #(
    .SEQ_BITS  (SEQ_BITS),
    .PREG_BITS (PREG_BITS)
  ) reorder_buf (
    .clk       (clk),
    .rst       (rst),
    .ins_en    (x_val),
    .ins_idx   (x_seq_num),
    .ins_pc    (x_pc),
    .ins_waddr (x_waddr),
    .ins_wdata (x_wdata),
    .ins_wen   (x_wen && (x_waddr != '0)),
    .ins_ppreg (x_ppreg),
    .head      (rob_head),
    .deq_val   (cmt_val),
    .deq_pc    (cmt_pc),
    .deq_waddr (cmt_waddr),
    .deq_wdata (cmt_wdata),
    .deq_wen   (cmt_wen),
    .deq_ppreg (cmt_ppreg)
  );

  // The head is the sequence number being committed
  assign cmt_seq_num = rob_head;

endmodule
